// File: hdl/dma_params.svh
// Shared widths and FIFO depth; addresses count bytes, lengths count 32-bit words, 0 is illegal
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Local byte address on the read bus
`define DMA_ADDR_WIDTH 32

// Bus data word and flit payload
`define DMA_DATA_WIDTH 32

// Transfer length in words
`define DMA_SIZE_WIDTH 8

// Destination tile id on the NoC
`define DMA_DEST_WIDTH 5

// Skid depth: timing decoupling, back-pressure latency, burst termination
`define DMA_FIFO_DEPTH 3

`endif

// File: hdl/dma_pkg.sv
// Request and flit types; header layout assumes DMA_DEST_WIDTH <= 8 and DMA_DATA_WIDTH >= 16
`include "dma_params.svh"

package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer request
  ////////////////////////////////////////////////////////////////////////////

  // Word-aligned local start address, length in words, target tile
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] laddr;
    logic [`DMA_SIZE_WIDTH-1:0] size;
    logic [`DMA_DEST_WIDTH-1:0] dest;
  } dma_req_t;

  ////////////////////////////////////////////////////////////////////////////
  // NoC flit
  ////////////////////////////////////////////////////////////////////////////

  // Last marks the final flit of a packet
  typedef struct packed {
    logic                       last;
    logic [`DMA_DATA_WIDTH-1:0] data;
  } flit_t;

  // Header payload
  // dest in bits 4:0, size in bits 15:8, rest zero
  function automatic logic [`DMA_DATA_WIDTH-1:0] header_data(dma_req_t r);
    logic [`DMA_DATA_WIDTH-1:0] h;
    h = '0;
    h[`DMA_DEST_WIDTH-1:0] = r.dest;
    h[8 +: `DMA_SIZE_WIDTH] = r.size;
    return h;
  endfunction

endpackage

// File: hdl/bus_pkg.sv
// AHB-Lite style read bus; write data, write enable, protection and transfer type are tied off
`include "dma_params.svh"

package bus_pkg;

  // Burst encoding, only incrementing and termination are used
  typedef logic [2:0] burst_t;

  localparam burst_t burst_incr = 3'd2;
  localparam burst_t burst_end  = 3'd7;

  // Initiator side
  // addr and burst only mean something while sel is high
  typedef struct packed {
    logic                       sel;
    logic                       mastlock;
    logic [`DMA_ADDR_WIDTH-1:0] addr;
    burst_t                     burst;
  } bus_req_t;

  // Target side
  // A word is taken on each edge with sel and ready high
  typedef struct packed {
    logic [`DMA_DATA_WIDTH-1:0] rdata;
    logic                       ready;
  } bus_rsp_t;

endpackage

// File: hdl/dma_skid_fifo.sv
// Three-entry skid FIFO; ready drops at two entries so one push in flight still fits
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_skid_fifo #(
  parameter type payload_t = logic [`DMA_DATA_WIDTH-1:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     empty,
  output logic     ready
);

  localparam int depth = `DMA_FIFO_DEPTH;

  // Storage, entry 0 is always the head
  payload_t mem [depth];

  // One-hot next free slot, top bit set means full
  logic [depth:0] pos;

  logic do_pop;

  // Popping an empty FIFO is ignored
  assign do_pop = pop & ~empty;

  assign empty = pos[0];
  assign dout  = mem[0];

  // High water, taken straight from the position register
  assign ready = ~|pos[depth:depth-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= {{depth{1'b0}}, 1'b1};
    end else if (push && !do_pop) begin
      pos <= pos << 1;
    end else if (!push && do_pop) begin
      pos <= pos >> 1;
    end
  end

  // Shift towards the head on pop; a push lands one slot lower then
  always_ff @(posedge clk) begin
    for (int i = 0; i < depth - 1; i++) begin
      if (do_pop) begin
        mem[i] <= (push && pos[i+1]) ? din : mem[i+1];
      end else if (push && pos[i]) begin
        mem[i] <= din;
      end
    end
    // Tail entry has nothing above it to shift in
    if (do_pop ? (push && pos[depth]) : (push && pos[depth-1])) begin
      mem[depth-1] <= din;
    end
  end

endmodule

// File: hdl/dma_bus_reader.sv
// Burst read FSM; assumes a word-aligned laddr and a nonzero size held stable during the transfer
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_bus_reader (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  dma_pkg::dma_req_t          req,
  output bus_pkg::bus_req_t          bus_req,
  input  bus_pkg::bus_rsp_t          bus_rsp,
  output logic                       word_valid,
  output logic [`DMA_DATA_WIDTH-1:0] word_data,
  input  logic                       word_ready
);

  //////////////////////////////////////////////////////////////////////////
  // State and counters
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_wait
  } state_t;

  state_t state;
  state_t state_nxt;

  // Words already taken from the bus
  logic [`DMA_SIZE_WIDTH-1:0] count;
  logic [`DMA_SIZE_WIDTH-1:0] count_nxt;

  logic last_word;
  logic fifo_push;
  logic fifo_ready;
  logic fifo_empty;

  assign last_word = (count == req.size - 1'b1);

  //////////////////////////////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    count_nxt = count;
    fifo_push = 1'b0;
    bus_req   = '0;
    case (state)
      st_idle: begin
        count_nxt = '0;
        // FIFO is empty here, so go straight to fetching
        if (start) begin
          state_nxt = st_fetch;
        end
      end
      st_fetch: begin
        bus_req.sel      = 1'b1;
        bus_req.mastlock = 1'b1;
        // Counter is in words, address in bytes
        bus_req.addr     = req.laddr + {count, 2'b00};
        // Terminate when the FIFO fills next cycle or on the final word
        bus_req.burst    = (!fifo_ready || last_word) ? bus_pkg::burst_end
                                                      : bus_pkg::burst_incr;
        if (bus_rsp.ready) begin
          fifo_push = 1'b1;
          count_nxt = count + 1'b1;
          if (last_word) begin
            state_nxt = st_idle;
          end else if (!fifo_ready) begin
            // This word takes the spare entry, pause the burst
            state_nxt = st_wait;
          end
        end
      end
      st_wait: begin
        // Restart at the next address once the FIFO drains
        if (fifo_ready) begin
          state_nxt = st_fetch;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      count <= '0;
    end else begin
      state <= state_nxt;
      count <= count_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Word side
  //////////////////////////////////////////////////////////////////////////

  dma_skid_fifo #(
    .payload_t (logic [`DMA_DATA_WIDTH-1:0])
  ) word_fifo_inst (
    .clk   (clk),
    .rst   (rst),
    .push  (fifo_push),
    .din   (bus_rsp.rdata),
    .pop   (word_ready),
    .dout  (word_data),
    .empty (fifo_empty),
    .ready (fifo_ready)
  );

  assign word_valid = ~fifo_empty;

endmodule

// File: hdl/dma_noc_packetizer.sv
// One packet per request: header flit then size data flits; last set only on the final data flit
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_noc_packetizer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  dma_pkg::dma_req_t          req,
  input  logic                       word_valid,
  input  logic [`DMA_DATA_WIDTH-1:0] word_data,
  output logic                       word_ready,
  output logic                       flit_valid,
  output dma_pkg::flit_t             flit,
  input  logic                       flit_ready,
  output logic                       done
);

  typedef enum logic [1:0] {
    st_idle,
    st_header,
    st_payload
  } state_t;

  state_t state;

  // Data words still to be packed
  logic [`DMA_SIZE_WIDTH-1:0] remaining;

  logic           out_push;
  logic           out_ready;
  logic           out_empty;
  dma_pkg::flit_t out_din;

  // Take a word only when the output FIFO can hold its flit
  assign word_ready = (state == st_payload) && out_ready;

  always_comb begin
    out_push = 1'b0;
    out_din  = '0;
    case (state)
      st_header: begin
        out_push     = out_ready;
        out_din.data = dma_pkg::header_data(req);
      end
      st_payload: begin
        out_push     = word_valid && word_ready;
        out_din.last = (remaining == 1'b1);
        out_din.data = word_data;
      end
      default: begin
        out_push = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      remaining <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_header;
            remaining <= req.size;
          end
        end
        st_header: begin
          if (out_ready) begin
            state <= st_payload;
          end
        end
        st_payload: begin
          if (out_push) begin
            remaining <= remaining - 1'b1;
            // Final word packed
            if (remaining == 1'b1) begin
              state <= st_idle;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Output skid, also the source of back-pressure towards the bus
  dma_skid_fifo #(
    .payload_t (dma_pkg::flit_t)
  ) flit_fifo_inst (
    .clk   (clk),
    .rst   (rst),
    .push  (out_push),
    .din   (out_din),
    .pop   (flit_ready),
    .dout  (flit),
    .empty (out_empty),
    .ready (out_ready)
  );

  assign flit_valid = ~out_empty;

  // Packet complete when the last flit is handed over
  assign done = flit_valid && flit_ready && flit.last;

endmodule

// File: hdl/dma_read_engine.sv
// Read DMA top; one request in flight, no queuing, req_ready returns after the last flit transfers
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_read_engine (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  dma_pkg::dma_req_t req,
  output logic              req_ready,
  output bus_pkg::bus_req_t bus_req,
  input  bus_pkg::bus_rsp_t bus_rsp,
  output logic              flit_valid,
  output dma_pkg::flit_t    flit,
  input  logic              flit_ready
);

  logic                       busy;
  logic                       start;
  logic                       done;
  logic                       accept;
  dma_pkg::dma_req_t          cur_req;
  logic                       word_valid;
  logic                       word_ready;
  logic [`DMA_DATA_WIDTH-1:0] word_data;

  ////////////////////////////////////////////////////////////////////////////
  // Request handshake
  ////////////////////////////////////////////////////////////////////////////

  assign req_ready = ~busy;
  assign accept    = req_valid && req_ready;

  // Busy from acceptance until the packet leaves, start pulses once
  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // Held for the whole transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_req <= req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  dma_bus_reader dma_bus_reader_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .req        (cur_req),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_ready (word_ready)
  );

  dma_noc_packetizer dma_noc_packetizer_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .req        (cur_req),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_ready (word_ready),
    .flit_valid (flit_valid),
    .flit       (flit),
    .flit_ready (flit_ready),
    .done       (done)
  );

endmodule

// File: dv/dma_read_engine_checker.sv
// Protocol assertions bound into dma_read_engine; sampled on clk, most are off during reset
`timescale 1ns/1ps

module dma_read_engine_checker (
  input logic              clk,
  input logic              rst,
  input logic              req_valid,
  input logic              req_ready,
  input bus_pkg::bus_req_t bus_req,
  input logic              flit_valid,
  input dma_pkg::flit_t    flit,
  input logic              flit_ready
);

  // Request accepted and its last flit not yet taken
  logic in_flight;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 1'b0;
    end else if (req_valid && req_ready) begin
      in_flight <= 1'b1;
    end else if (flit_valid && flit_ready && flit.last) begin
      in_flight <= 1'b0;
    end
  end

  // Stalled flit stays put
  flit_stable: assert property (@(posedge clk) disable iff (rst)
    (flit_valid && !flit_ready) |=> (flit_valid && $stable(flit)))
    else $error("flit changed or dropped while flit_ready was low");

  reset_idle: assert property (@(posedge clk)
    rst |=> (!bus_req.sel && !flit_valid))
    else $error("bus sel or flit_valid high after reset");

  addr_aligned: assert property (@(posedge clk) disable iff (rst)
    bus_req.sel |-> (bus_req.addr[1:0] == 2'b00))
    else $error("bus address not word aligned");

  busy_not_ready: assert property (@(posedge clk) disable iff (rst)
    in_flight |-> !req_ready)
    else $error("req_ready high before the last flit of the packet");

endmodule

bind dma_read_engine dma_read_engine_checker dma_read_engine_checker_inst (
  .clk        (clk),
  .rst        (rst),
  .req_valid  (req_valid),
  .req_ready  (req_ready),
  .bus_req    (bus_req),
  .flit_valid (flit_valid),
  .flit       (flit),
  .flit_ready (flit_ready)
);

// File: dv/dma_read_engine_tb.sv
// Random reads against a memory model and a flit scoreboard; seed 76106, lengths 1 to 16 words
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_read_engine_tb;

  localparam int timeout_cycles = 5000;

  logic              clk;
  logic              rst;
  logic              req_valid;
  dma_pkg::dma_req_t req;
  logic              req_ready;
  bus_pkg::bus_req_t bus_req;
  bus_pkg::bus_rsp_t bus_rsp;
  logic              mem_ready;
  logic              flit_valid;
  dma_pkg::flit_t    flit;
  logic              flit_ready;

  // Request stream and bus/NoC stall stream are kept apart
  logic [31:0] stim_rng;
  logic [31:0] side_rng;
  int          mem_stall_pct;
  int          flit_stall_pct;

  // Byte address of the final word of the request in flight
  logic [`DMA_ADDR_WIDTH-1:0] final_addr;

  // Scoreboard, oldest flit first
  dma_pkg::flit_t expected [$];
  int             errors;
  int             flits_seen;
  int             tests_passed;
  int             tests_failed;
  logic           aborted;

  dma_read_engine dma_read_engine_inst (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .flit_valid (flit_valid),
    .flit       (flit),
    .flit_ready (flit_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory and NoC sink models
  ////////////////////////////////////////////////////////////////////////////

  // Word at byte address A reads as A xor C0DE0000
  // Read data is zero while sel is low
  assign bus_rsp = {bus_req.sel ? (bus_req.addr ^ 32'hC0DE0000) : 32'h0, mem_ready};

  // Random wait states and flit back-pressure
  always @(posedge clk) begin : side_drive
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = xorshift32(side_rng);
    r2 = xorshift32(r1);
    side_rng   <= r2;
    mem_ready  <= int'(r1 % 32'd100) >= mem_stall_pct;
    flit_ready <= int'(r2 % 32'd100) >= flit_stall_pct;
  end

  always @(posedge clk) begin : flit_sink
    dma_pkg::flit_t want;
    if (!rst && flit_valid && flit_ready) begin
      flits_seen++;
      if (expected.size() == 0) begin
        $display("Flit %h arrived with no packet outstanding", flit);
        errors++;
      end else begin
        want = expected.pop_front();
        if (flit !== want) begin
          $display("Mismatch flit: expected %h, got %h", want, flit);
          errors++;
        end
      end
    end
  end

  // Burst terminates on the final word of the request
  always @(posedge clk) begin : burst_check
    if (!rst && bus_req.sel && mem_ready && bus_req.addr == final_addr) begin
      if (bus_req.burst !== bus_pkg::burst_end) begin
        $display("Mismatch bus_req.burst: expected %h, got %h",
                 bus_pkg::burst_end, bus_req.burst);
        errors++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic dma_pkg::dma_req_t random_req(input int min_size, input int max_size);
    dma_pkg::dma_req_t r;
    stim_rng = xorshift32(stim_rng);
    r.laddr  = {stim_rng[31:2], 2'b00};
    stim_rng = xorshift32(stim_rng);
    r.size   = `DMA_SIZE_WIDTH'(min_size + int'(stim_rng % (max_size - min_size + 1)));
    stim_rng = xorshift32(stim_rng);
    r.dest   = stim_rng[`DMA_DEST_WIDTH-1:0];
    return r;
  endfunction

  // Header first, then one flit per word with last on the final one
  task automatic queue_packet(input dma_pkg::dma_req_t r);
    dma_pkg::flit_t f;
    f = '0;
    f.data[`DMA_DEST_WIDTH-1:0] = r.dest;
    f.data[15:8] = r.size;
    expected.push_back(f);
    for (int i = 0; i < int'(r.size); i++) begin
      f.last = (i == int'(r.size) - 1);
      f.data = (r.laddr + `DMA_ADDR_WIDTH'(4 * i)) ^ 32'hC0DE0000;
      expected.push_back(f);
    end
  endtask

  // Called right after a clock edge, returns on the accepting edge
  task automatic send_req(input dma_pkg::dma_req_t r);
    int waited;
    waited    = 0;
    req_valid <= 1'b1;
    req       <= r;
    @(posedge clk);
    while (!req_ready && waited < timeout_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (!req_ready) begin
      $display("Timeout: request was never accepted");
      errors++;
      aborted = 1'b1;
    end else begin
      // Accepting while flits remain means packets could interleave
      if (expected.size() != 0) begin
        $display("Request accepted with %0d flits of the last packet outstanding",
                 expected.size());
        errors++;
      end
      final_addr <= r.laddr + `DMA_ADDR_WIDTH'(4 * (int'(r.size) - 1));
      queue_packet(r);
    end
  endtask

  // req_ready high again means the last flit went out on an earlier edge
  task automatic wait_drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!req_ready && waited < timeout_cycles);
    if (!req_ready) begin
      $display("Timeout: packet never finished, %0d flits missing", expected.size());
      errors++;
      aborted = 1'b1;
    end else if (expected.size() != 0) begin
      $display("Engine went idle with %0d flits never delivered", expected.size());
      errors++;
    end
  endtask

  task automatic run_test(input int id, input string name, input int count,
                          input int min_size, input int max_size, input int mem_stall,
                          input int flit_stall, input bit back_to_back);
    int start_errors;
    start_errors = errors;
    if (aborted) begin
      $display("Test %0d %s: skipped after an earlier timeout", id, name);
      tests_failed++;
      return;
    end
    mem_stall_pct  <= mem_stall;
    flit_stall_pct <= flit_stall;
    for (int n = 0; n < count && !aborted; n++) begin
      send_req(random_req(min_size, max_size));
      if (!back_to_back) begin
        req_valid <= 1'b0;
        if (!aborted) wait_drain();
      end
    end
    if (back_to_back && !aborted) begin
      req_valid <= 1'b0;
      wait_drain();
    end
    if (errors == start_errors) begin
      tests_passed++;
      $display("Test %0d %s: passed, %0d requests", id, name, count);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed, %0d errors", id, name, errors - start_errors);
    end
  endtask

  initial begin
    rst            = 1'b1;
    req_valid      = 1'b0;
    req            = '0;
    mem_ready      = 1'b0;
    flit_ready     = 1'b0;
    final_addr     = '0;
    stim_rng       = 32'd76106;
    side_rng       = 32'd76106 ^ 32'h9E3779B9;
    mem_stall_pct  = 0;
    flit_stall_pct = 0;
    errors         = 0;
    flits_seen     = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    aborted        = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    run_test(1, "single word", 1, 1, 1, 0, 0, 1'b0);
    run_test(2, "random length with bus waits", 20, 1, 16, 50, 0, 1'b0);
    run_test(3, "long bursts under back-pressure", 20, 12, 16, 20, 75, 1'b0);
    run_test(4, "header fields", 50, 1, 16, 25, 25, 1'b0);
    run_test(5, "back-to-back requests", 20, 1, 16, 30, 40, 1'b1);
    $display("Tests passed %0d, failed %0d, flits checked %0d, errors %0d",
             tests_passed, tests_failed, flits_seen, errors);
    if (errors == 0 && !aborted) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/dma_pkg.sv
hdl/bus_pkg.sv
hdl/dma_skid_fifo.sv
hdl/dma_bus_reader.sv
hdl/dma_noc_packetizer.sv
hdl/dma_read_engine.sv
dv/dma_read_engine_checker.sv
dv/dma_read_engine_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the DMA read engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Something failed"

verilator --binary --assert -Wno-fatal --top-module dma_read_engine_tb \
  -f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vdma_read_engine_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation passed"
exit 0
